// File: source/vlane_pkg.sv
// --------------------------------------------------------------------------
// vector lane package: element widths, unit and opcode encodings, the
// issue and result records shared by the queue, the units and the arbiter.
// --------------------------------------------------------------------------
package vlane_pkg;

  localparam int data_w = 32;  // element width.
  localparam int tag_w  = 4;   // operation tag width.

  // functional unit selected by an issued operation.
  typedef enum logic [1:0] {
    arith = 2'd0,  // add, logic, shifts, min.
    mul   = 2'd1,  // pipelined multiply.
    div   = 2'd2   // serial divide.
  } fu_type_e;

  // element opcodes, only the ones the target unit knows are meaningful.
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,
    op_sll  = 4'd5,   // shift amount from src_b[4:0].
    op_srl  = 4'd6,   // logical right shift.
    op_min  = 4'd7,   // unsigned minimum.
    op_mul  = 4'd8,   // low half of the product.
    op_divu = 4'd9,   // unsigned quotient.
    op_remu = 4'd10   // unsigned remainder.
  } alu_op_e;

  // one operation as it comes from the dispatcher.
  typedef struct packed {
    fu_type_e            fu;     // target unit.
    alu_op_e             op;     // opcode.
    logic [tag_w-1:0]    tag;    // returned with the result.
    logic [data_w-1:0]   src_a;  // first operand.
    logic [data_w-1:0]   src_b;  // second operand.
  } lane_op_t;

  // one finished result on the shared writeback bus.
  typedef struct packed {
    logic [tag_w-1:0]    tag;    // tag of the producing operation.
    logic [data_w-1:0]   data;   // element result.
  } lane_result_t;

endpackage

// File: source/lane_issue.sv
// --------------------------------------------------------------------------
// issue queue: buffers credited operations and starts the head on its unit.
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module lane_issue #(
  parameter int ISSUE_DEPTH = 4
) (
  input  logic                CLK,
  input  logic                rst_n,
  input  logic                iss_valid,
  input  vlane_pkg::lane_op_t iss_op,
  output logic                credit_return,
  output logic                start_a,
  output logic                start_m,
  output logic                start_d,
  output vlane_pkg::lane_op_t unit_op,
  input  logic                ready_a,
  input  logic                ready_m,
  input  logic                ready_d
);

  localparam int ptr_w = (ISSUE_DEPTH > 1) ? $clog2(ISSUE_DEPTH) : 1;
  localparam int cnt_w = $clog2(ISSUE_DEPTH + 1);

  vlane_pkg::lane_op_t mem [ISSUE_DEPTH];  // queue storage.
  logic [ptr_w-1:0]    wr_ptr, rd_ptr;
  logic [cnt_w-1:0]    count;               // occupied entries.
  logic                not_empty, full, push, pop;

  assign not_empty = (count != '0);
  assign full      = (count == cnt_w'(ISSUE_DEPTH));
  assign push      = iss_valid;              // credits guarantee space.
  assign unit_op   = mem[rd_ptr];            // head goes to all units.

  // steer the head by its fu field, only into a unit that is ready.
  assign start_a = not_empty && (unit_op.fu == vlane_pkg::arith) && ready_a;
  assign start_m = not_empty && (unit_op.fu == vlane_pkg::mul)   && ready_m;
  assign start_d = not_empty && (unit_op.fu == vlane_pkg::div)   && ready_d;
  assign pop     = start_a | start_m | start_d;
  assign credit_return = pop;                // one credit per departure.

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == ptr_w'(ISSUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == ptr_w'(ISSUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (push) mem[wr_ptr] <= iss_op;  // payload, no reset.
  end

  // the dispatcher may only issue while it holds a credit.
  a_no_push_full: assert property (@(posedge CLK) disable iff (!rst_n)
    !(iss_valid && full));

endmodule

// File: source/arith_unit.sv
// --------------------------------------------------------------------------
// arithmetic unit: one-cycle add, sub, logic, shifts and unsigned min,
// parked in a single holding register until the writeback grant.
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module arith_unit (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    start,
  input  vlane_pkg::lane_op_t     op,
  output logic                    ready,
  output logic                    req,
  output vlane_pkg::lane_result_t res,
  input  logic                    grant
);

  logic [vlane_pkg::data_w-1:0] alu_data;  // combinational result.
  logic [4:0]                   shamt;
  logic                         hold_vld;  // holding register occupied.
  vlane_pkg::lane_result_t      hold_res;

  assign shamt = op.src_b[4:0];

  always_comb begin
    case (op.op)
      vlane_pkg::op_add: alu_data = op.src_a + op.src_b;
      vlane_pkg::op_sub: alu_data = op.src_a - op.src_b;
      vlane_pkg::op_and: alu_data = op.src_a & op.src_b;
      vlane_pkg::op_or:  alu_data = op.src_a | op.src_b;
      vlane_pkg::op_xor: alu_data = op.src_a ^ op.src_b;
      vlane_pkg::op_sll: alu_data = op.src_a << shamt;
      vlane_pkg::op_srl: alu_data = op.src_a >> shamt;
      vlane_pkg::op_min: alu_data = (op.src_a < op.src_b) ? op.src_a : op.src_b;  // unsigned.
      default:           alu_data = '0;  // other units' opcodes.
    endcase
  end

  // free now, or freed by the grant this cycle.
  assign ready = !hold_vld || grant;
  assign req   = hold_vld;
  assign res   = hold_res;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      hold_vld <= 1'b0;
    end else if (start) begin
      hold_vld <= 1'b1;         // new result replaces the granted one.
    end else if (grant) begin
      hold_vld <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (start) hold_res <= '{tag: op.tag, data: alu_data};
  end

endmodule

// File: source/mul_unit.sv
// --------------------------------------------------------------------------
// multiply unit: partial products in front, summed into the output
// register, whole pipe frozen while the output waits for its grant.
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module mul_unit #(
  parameter int MUL_STAGES = 3
) (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    start,
  input  vlane_pkg::lane_op_t     op,
  output logic                    ready,
  output logic                    req,
  output vlane_pkg::lane_result_t res,
  input  logic                    grant
);

  localparam int pp_n = MUL_STAGES - 1;  // stages before the output register.

  logic [MUL_STAGES-1:0]       vld;            // last bit is the output register.
  logic [vlane_pkg::tag_w-1:0] tag   [pp_n];
  logic [31:0]                 pp_lo [pp_n];   // src_a * src_b[15:0].
  logic [15:0]                 pp_hi [pp_n];   // src_a[15:0] * src_b[31:16], low half.
  vlane_pkg::lane_result_t     out_res;
  logic                        advance;

  assign advance = !vld[MUL_STAGES-1] || grant;  // stall on a held output.
  assign ready   = advance;
  assign req     = vld[MUL_STAGES-1];
  assign res     = out_res;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else if (advance) begin
      vld <= {vld[MUL_STAGES-2:0], start};  // shift valids with the data.
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      tag[0]   <= op.tag;
      pp_lo[0] <= op.src_a * op.src_b[15:0];          // keeps low 32 bits.
      pp_hi[0] <= op.src_a[15:0] * op.src_b[31:16];   // only bits below 2^32 count.
      for (int i = 1; i < pp_n; i++) begin
        tag[i]   <= tag[i-1];
        pp_lo[i] <= pp_lo[i-1];
        pp_hi[i] <= pp_hi[i-1];
      end
      out_res.tag  <= tag[pp_n-1];
      out_res.data <= pp_lo[pp_n-1] + {pp_hi[pp_n-1], 16'h0000};  // low product.
    end
  end

endmodule

// File: source/div_unit.sv
// --------------------------------------------------------------------------
// divide unit: restoring serial divider, one quotient bit per cycle.
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module div_unit (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    start,
  input  vlane_pkg::lane_op_t     op,
  output logic                    ready,
  output logic                    req,
  output vlane_pkg::lane_result_t res,
  input  logic                    grant
);

  typedef enum logic [1:0] {
    idle = 2'd0,
    run  = 2'd1,
    done = 2'd2
  } div_state_e;

  div_state_e                  state;
  logic [4:0]                  cnt;      // iteration count.
  logic [31:0]                 quo;      // dividend shifts out, quotient shifts in.
  logic [31:0]                 rem;      // partial remainder.
  logic [31:0]                 dvsr;
  logic                        is_rem;   // op_remu selects the remainder.
  logic [vlane_pkg::tag_w-1:0] tag_q;
  logic [32:0]                 trial;    // shifted remainder minus divisor.

  assign trial = {rem, quo[31]} - {1'b0, dvsr};

  assign ready    = (state == idle);
  assign req      = (state == done);
  assign res.tag  = tag_q;
  assign res.data = is_rem ? rem : quo;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      cnt   <= '0;
    end else begin
      case (state)
        idle: if (start) begin
          state <= run;                      // load cycle.
          cnt   <= '0;
        end
        run: begin
          cnt <= cnt + 1'b1;
          if (cnt == 5'd31) state <= done;   // 32 iterations.
        end
        done: if (grant) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // zero divisor never fails the trial, so quotient is all ones and the
  // remainder collects the whole dividend.
  always_ff @(posedge CLK) begin
    if (state == idle && start) begin
      quo    <= op.src_a;
      rem    <= '0;
      dvsr   <= op.src_b;
      is_rem <= (op.op == vlane_pkg::op_remu);
      tag_q  <= op.tag;
    end else if (state == run) begin
      if (!trial[32]) rem <= trial[31:0];    // subtract succeeded.
      else            rem <= {rem[30:0], quo[31]};  // restore.
      quo <= {quo[30:0], ~trial[32]};
    end
  end

  // the queue only starts this unit while it reports ready.
  a_start_idle: assert property (@(posedge CLK) disable iff (!rst_n)
    start |-> state == idle);

endmodule

// File: source/wb_arbiter.sv
// --------------------------------------------------------------------------
// writeback arbiter: round-robin among the three units onto one result bus.
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module wb_arbiter (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic [2:0]              req,
  input  vlane_pkg::lane_result_t res_a,
  input  vlane_pkg::lane_result_t res_m,
  input  vlane_pkg::lane_result_t res_d,
  output logic [2:0]              grant,
  input  logic                    res_ready,
  output logic                    res_valid,
  output vlane_pkg::lane_result_t res
);

  logic [1:0] last;   // index of the unit granted last.
  logic [1:0] win;    // next unit in rotation that is requesting.
  logic       found;

  always_comb begin
    int idx;
    idx   = 0;
    win   = last;
    found = 1'b0;
    for (int k = 1; k <= 3; k++) begin
      idx = (int'(last) + k) % 3;      // search starts after last.
      if (!found && req[idx]) begin
        win   = 2'(idx);
        found = 1'b1;
      end
    end
  end

  assign res_valid = found;
  assign grant     = (found && res_ready) ? (3'b001 << win) : 3'b000;  // transfer.

  always_comb begin
    case (win)
      2'd0:    res = res_a;
      2'd1:    res = res_m;
      default: res = res_d;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      last <= 2'd2;                    // arith unit first after reset.
    end else if (|grant) begin
      last <= win;
    end
  end

  a_grant_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
    $onehot0(grant));

endmodule

// File: source/vector_lane.sv
// --------------------------------------------------------------------------
// vector lane top: issue queue, three functional units, writeback arbiter.
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module vector_lane #(
  parameter int ISSUE_DEPTH = 4,
  parameter int MUL_STAGES  = 3
) (
  input  logic                    CLK,
  input  logic                    rst_n,
  input  logic                    iss_valid,
  input  vlane_pkg::lane_op_t     iss_op,
  output logic                    credit_return,
  output logic                    res_valid,
  output vlane_pkg::lane_result_t res,
  input  logic                    res_ready
);

  logic                    start_a, start_m, start_d;
  logic                    ready_a, ready_m, ready_d;
  vlane_pkg::lane_op_t     unit_op;        // head operation to all units.
  logic [2:0]              req, grant;     // bit 0 arith, 1 mul, 2 div.
  vlane_pkg::lane_result_t res_a, res_m, res_d;

  lane_issue #(.ISSUE_DEPTH(ISSUE_DEPTH)) issue_i (
    .CLK, .rst_n, .iss_valid, .iss_op, .credit_return,
    .start_a, .start_m, .start_d, .unit_op,
    .ready_a, .ready_m, .ready_d
  );

  arith_unit arith_i (
    .CLK, .rst_n, .start(start_a), .op(unit_op), .ready(ready_a),
    .req(req[0]), .res(res_a), .grant(grant[0])
  );

  mul_unit #(.MUL_STAGES(MUL_STAGES)) mul_i (
    .CLK, .rst_n, .start(start_m), .op(unit_op), .ready(ready_m),
    .req(req[1]), .res(res_m), .grant(grant[1])
  );

  div_unit div_i (
    .CLK, .rst_n, .start(start_d), .op(unit_op), .ready(ready_d),
    .req(req[2]), .res(res_d), .grant(grant[2])
  );

  wb_arbiter arb_i (
    .CLK, .rst_n, .req, .res_a, .res_m, .res_d,
    .grant, .res_ready, .res_valid, .res
  );

endmodule

// File: tb/tb_clk_gen.sv
// --------------------------------------------------------------------------
// testbench clock and reset: 40 ns clock, reset held low for 5 edges.
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int period_ns  = 40,
  parameter int rst_cycles = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;  // free running.
  end

  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #2 rst_n = 1'b1;                      // release off the edge.
  end

endmodule

// File: tb/vector_lane_tb.sv
// --------------------------------------------------------------------------
// vector lane testbench with table-driven credited issue, tagged result
// checks and random writeback back-pressure.
// --------------------------------------------------------------------------
`timescale 1ns/10ps

module vector_lane_tb;

  localparam int n_ops    = 16;    // table entries with one tag each.
  localparam int depth    = 4;     // issue queue depth and credit count.
  localparam int wait_max = 2000;  // cycle limit of every wait loop.

  logic                    clk, rst_n;
  logic                    iss_valid;
  vlane_pkg::lane_op_t     iss_op;
  logic                    credit_return;
  logic                    res_valid;
  vlane_pkg::lane_result_t res;
  logic                    res_ready;

  vlane_pkg::lane_op_t     stim       [n_ops];  // operations by tag.
  vlane_pkg::lane_result_t expect_res [n_ops];  // expected results by tag.
  int seen_cnt   [n_ops];                       // arrivals per tag.
  int arrive_pos [n_ops];                       // arrival order or -1 if none.
  int n_arrived;
  int credits;                                  // dispatcher credits.
  bit random_ready;                             // back-pressure on.
  int value_errs, tag_errs, credit_errs, timeout_errs;
  int seed_val;

  tb_clk_gen #(.period_ns(40), .rst_cycles(5)) clk_gen_i (.clk, .rst_n);

  vector_lane #(.ISSUE_DEPTH(depth), .MUL_STAGES(3)) dut_i (
    .CLK(clk), .rst_n, .iss_valid, .iss_op, .credit_return,
    .res_valid, .res, .res_ready
  );

  task automatic set_entry(input int idx, input vlane_pkg::fu_type_e fu,
                           input vlane_pkg::alu_op_e op, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] exp_data);
    stim[idx].fu          = fu;
    stim[idx].op          = op;
    stim[idx].tag         = idx[vlane_pkg::tag_w-1:0];
    stim[idx].src_a       = a;
    stim[idx].src_b       = b;
    expect_res[idx].tag   = idx[vlane_pkg::tag_w-1:0];
    expect_res[idx].data  = exp_data;
  endtask

  task automatic build_table();
    // entries 0 and 1 are the divide then add pair for the order check.
    set_entry(0,  vlane_pkg::div,   vlane_pkg::op_divu, 32'd100, 32'd7, 32'd14);
    set_entry(1,  vlane_pkg::arith, vlane_pkg::op_add,  32'h1234_5678, 32'h1111_1111,
              32'h2345_6789);
    set_entry(2,  vlane_pkg::arith, vlane_pkg::op_sub,  32'd5, 32'd7, 32'hffff_fffe);
    set_entry(3,  vlane_pkg::arith, vlane_pkg::op_and,  32'hf0f0_f0f0, 32'hff00_ff00,
              32'hf000_f000);
    set_entry(4,  vlane_pkg::arith, vlane_pkg::op_or,   32'h0f0f_0000, 32'h0000_00f0,
              32'h0f0f_00f0);
    set_entry(5,  vlane_pkg::arith, vlane_pkg::op_xor,  32'haaaa_5555, 32'hffff_0000,
              32'h5555_5555);
    set_entry(6,  vlane_pkg::arith, vlane_pkg::op_sll,  32'h0000_0003, 32'd31,
              32'h8000_0000);
    set_entry(7,  vlane_pkg::arith, vlane_pkg::op_srl,  32'h8000_0001, 32'h0000_003f,
              32'h0000_0001);  // only b[4:0] counts.
    set_entry(8,  vlane_pkg::arith, vlane_pkg::op_min,  32'hffff_fff0, 32'h0000_0010,
              32'h0000_0010);  // unsigned compare.
    set_entry(9,  vlane_pkg::mul,   vlane_pkg::op_mul,  32'h0001_0000, 32'h0001_0000, 32'd0);
    set_entry(10, vlane_pkg::mul,   vlane_pkg::op_mul,  32'd1234, 32'd5678, 32'd7006652);
    set_entry(11, vlane_pkg::mul,   vlane_pkg::op_mul,  32'hffff_ffff, 32'hffff_ffff, 32'd1);
    set_entry(12, vlane_pkg::div,   vlane_pkg::op_remu, 32'd100, 32'd7, 32'd2);
    set_entry(13, vlane_pkg::div,   vlane_pkg::op_divu, 32'h0000_1234, 32'd0, 32'hffff_ffff);
    set_entry(14, vlane_pkg::div,   vlane_pkg::op_remu, 32'h0000_1234, 32'd0, 32'h0000_1234);
    set_entry(15, vlane_pkg::mul,   vlane_pkg::op_mul,  32'h0001_0003, 32'h0002_0005,
              32'h000b_000f);
  endtask

  task automatic check_result(input vlane_pkg::lane_result_t got,
                              input vlane_pkg::lane_result_t exp);
    if (got !== exp) begin
      $display("Fail %0t: tag %0d data %h, expected tag %0d data %h",
               $time, got.tag, got.data, exp.tag, exp.data);
      value_errs++;
    end
  endtask

  task automatic check_credits(input int got, input int exp);
    if (got != exp) begin
      $display("Fail %0t: credit count %0d, expected %0d", $time, got, exp);
      credit_errs++;
    end
  endtask

  task automatic issue_ops(input int first, input int last);
    int idx;
    int stalled;
    idx     = first;
    stalled = 0;
    while (idx <= last && stalled < wait_max) begin
      @(posedge clk);
      #2;
      if (credits > 0) begin
        iss_valid = 1'b1;
        iss_op    = stim[idx];
        credits--;                     // spent on issue.
        idx++;
        stalled   = 0;
      end else begin
        iss_valid = 1'b0;              // out of credits so hold off.
        stalled++;
      end
    end
    @(posedge clk);
    #2;
    iss_valid = 1'b0;
    if (idx <= last) begin
      $display("dispatcher waited too long for a credit at %0t", $time);
      timeout_errs++;
    end
  endtask

  task automatic wait_results(input int n);
    int waited;
    waited = 0;
    while (n_arrived < n && waited < wait_max) begin
      @(posedge clk);
      waited++;
    end
    if (n_arrived < n) begin
      $display("only %0d of %0d results arrived before the timeout", n_arrived, n);
      timeout_errs++;
    end
  endtask

  task automatic check_order(input int early_tag, input int late_tag);
    if (arrive_pos[early_tag] < 0 || arrive_pos[late_tag] < 0 ||
        arrive_pos[early_tag] > arrive_pos[late_tag]) begin
      $display("tag %0d should have returned before tag %0d", early_tag, late_tag);
      tag_errs++;
    end
  endtask

  task automatic check_tags_once();
    for (int t = 0; t < n_ops; t++) begin
      if (seen_cnt[t] == 0) begin
        $display("tag %0d never came back", t);
        tag_errs++;
      end
    end
  endtask

  // result collector samples mid-cycle where the bus is stable.
  always @(negedge clk) begin
    if (rst_n && res_valid && res_ready) begin
      seen_cnt[res.tag]++;
      if (seen_cnt[res.tag] > 1) begin
        $display("tag %0d came back more than once at %0t", res.tag, $time);
        tag_errs++;
      end else begin
        check_result(res, expect_res[res.tag]);
        arrive_pos[res.tag] = n_arrived;  // order of first arrival.
      end
      n_arrived++;
    end
  end

  // credit returns are counted before the next issue decision.
  always @(negedge clk) begin
    if (rst_n && credit_return) begin
      credits++;
    end
    if (credits < 0 || credits > depth) begin
      $display("credit count left its range, now %0d at %0t", credits, $time);
      credit_errs++;
    end
  end

  // consumer back-pressure is low about one cycle in four.
  initial begin
    seed_val = $urandom(32'h7d4f_b431);  // one seed for the run.
    forever begin
      @(posedge clk);
      #2;
      res_ready = random_ready ? (($urandom % 4) != 0) : 1'b1;
    end
  end

  initial begin
    int waited;
    iss_valid    = 1'b0;
    iss_op       = '0;
    res_ready    = 1'b1;
    random_ready = 1'b0;
    credits      = depth;
    n_arrived    = 0;
    value_errs   = 0;
    tag_errs     = 0;
    credit_errs  = 0;
    timeout_errs = 0;
    for (int t = 0; t < n_ops; t++) begin
      seen_cnt[t]   = 0;
      arrive_pos[t] = -1;
    end
    build_table();
    waited = 0;
    while (rst_n !== 1'b1 && waited < 50) begin
      @(posedge clk);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("reset was never released");
      timeout_errs++;
    end
    issue_ops(0, 1);             // divide then add with ready held high.
    wait_results(2);
    check_order(1, 0);           // add overtakes the divide.
    random_ready = 1'b1;
    issue_ops(2, n_ops - 1);
    wait_results(n_ops);
    random_ready = 1'b0;
    check_tags_once();
    check_credits(credits, depth);  // all credits back after the drain.
    $display("errors: value %0d, tag %0d, credit %0d, timeout %0d",
             value_errs, tag_errs, credit_errs, timeout_errs);
    if (value_errs + tag_errs + credit_errs + timeout_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: compile.f
source/vlane_pkg.sv
source/lane_issue.sv
source/arith_unit.sv
source/mul_unit.sv
source/div_unit.sv
source/wb_arbiter.sv
source/vector_lane.sv
tb/tb_clk_gen.sv
tb/vector_lane_tb.sv

// File: Bender.yml
package:
  name: vector_lane

sources:
  - source/vlane_pkg.sv
  - source/lane_issue.sv
  - source/arith_unit.sv
  - source/mul_unit.sv
  - source/div_unit.sv
  - source/wb_arbiter.sv
  - source/vector_lane.sv
  - target: test
    files:
      - tb/tb_clk_gen.sv
      - tb/vector_lane_tb.sv
